// ==== ooo_cfg.svh ====
// ----------------------------------------------------------------------
// sizing macros for the completion side of the OoO pipeline
// buffer depth, word width, architectural register count
// ----------------------------------------------------------------------
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// completion buffer entries, power of two so the pointers wrap freely
`define OOO_CB_DEPTH 8

// data and address width
`define OOO_XLEN 32

// architectural integer registers
`define OOO_NREGS 32

`endif

// ==== ooo_types_pkg.sv ====
// ----------------------------------------------------------------------
// package ooo_types_pkg
// word, index and register types plus the two result lane payloads
// ----------------------------------------------------------------------
`include "ooo_cfg.svh"

package ooo_types_pkg;

  typedef logic [`OOO_XLEN-1:0] word_t;                      // data or address
  typedef logic [$clog2(`OOO_CB_DEPTH)-1:0] cb_index_t;     // completion buffer slot
  typedef logic [$clog2(`OOO_NREGS)-1:0] reg_addr_t;        // destination register

  // arithmetic lane, also resolves branches and jumps
  typedef struct packed {
    cb_index_t index;      // slot given at dispatch
    word_t     wdata;      // alu result
    word_t     pc;
    logic      exception;
    logic      branch;     // conditional branch
    logic      jump;       // unconditional jump
    logic      taken;      // resolved direction
    logic      prediction; // direction guessed at fetch
    word_t     target;     // resolved branch or jump target
  } arith_result_t;

  // long-latency lane (mul, div, load)
  typedef struct packed {
    cb_index_t index;
    word_t     wdata;
    word_t     pc;
    logic      exception;
  } long_result_t;

endpackage

// ==== result_reg.sv ====
// ----------------------------------------------------------------------
// module result_reg
// one-entry valid/ready register between a lane and writeback
// payload type set by parameter, contents dropped on flush
// ----------------------------------------------------------------------
module result_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data
);

  logic load; // input side transfers this cycle

  // writeback always drains, so only flush holds off the lane
  assign in_ready = ~flush;
  assign load     = in_valid & in_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;   // wrong-path result, discard
    end else begin
      out_valid <= load;   // presents one cycle, empties unless reloaded
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge CLK) begin
    if (load) begin
      out_data <= in_data;
    end
  end

  // a presented result carries a fully driven payload
  a_payload_known: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid |-> !$isunknown(out_data));

endmodule

// ==== ooo_writeback_stage.sv ====
// ----------------------------------------------------------------------
// module ooo_writeback_stage
// per-lane write word, register enable and redirect selection
// branch predictor update from the arithmetic lane
// ----------------------------------------------------------------------
module ooo_writeback_stage import ooo_types_pkg::*; (
  // arithmetic lane from its result register
  input  logic          arith_valid,
  input  arith_result_t arith_data,
  // long-latency lane from its result register
  input  logic          long_valid,
  input  long_result_t  long_data,
  // arithmetic lane write port into the completion buffer
  output logic          wa_en,
  output cb_index_t     wa_index,
  output word_t         wa_wdata,
  output logic          wa_wen,
  output logic          wa_redirect,
  // long lane write port
  output logic          wl_en,
  output cb_index_t     wl_index,
  output word_t         wl_wdata,
  output logic          wl_wen,
  output logic          wl_redirect,
  // predictor update strobe
  output logic          pred_update,
  output logic          pred_taken,
  output word_t         pred_target
);

  logic arith_mispredict;  // branch went the other way
  logic arith_use_target;  // store the resolved target
  logic arith_no_regwrite; // nothing architectural lands in rd

  assign arith_mispredict  = arith_data.branch & (arith_data.taken ^ arith_data.prediction);
  assign arith_use_target  = arith_mispredict | arith_data.jump;
  // branches have no rd, excepting instructions must not update state
  assign arith_no_regwrite = arith_data.branch | arith_data.exception;

  // arithmetic lane
  assign wa_en    = arith_valid;      // buffer never back-pressures
  assign wa_index = arith_data.index;

  always_comb begin
    // target wins over pc, pc wins over the result
    if (arith_use_target) begin
      wa_wdata = arith_data.target;
    end else if (arith_data.exception) begin
      wa_wdata = arith_data.pc;     // pc kept for the trap handler
    end else begin
      wa_wdata = arith_data.wdata;
    end
  end

  assign wa_wen      = ~arith_no_regwrite; // jumps still link into rd
  // each of these ends the current fetch path
  assign wa_redirect = arith_use_target | arith_data.exception;

  // long lane, exceptions only
  assign wl_en       = long_valid;
  assign wl_index    = long_data.index;
  assign wl_wdata    = long_data.exception ? long_data.pc : long_data.wdata;
  assign wl_wen      = ~long_data.exception;
  assign wl_redirect = long_data.exception;

  // predictor training, one strobe per branch while it sits valid
  assign pred_update = arith_valid & arith_data.branch;
  assign pred_taken  = pred_update & arith_data.taken;
  assign pred_target = arith_data.target;

endmodule

// ==== completion_buffer.sv ====
// ----------------------------------------------------------------------
// module completion_buffer
// in-order allocation, indexed result writes from two lanes
// in-order retirement with redirect and full flush
// ----------------------------------------------------------------------
`include "ooo_cfg.svh"

module completion_buffer import ooo_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  // dispatch
  input  logic      alloc_valid,
  input  reg_addr_t alloc_rd,
  output logic      alloc_ready,
  output cb_index_t alloc_index,
  // arithmetic lane write port
  input  logic      wa_en,
  input  cb_index_t wa_index,
  input  word_t     wa_wdata,
  input  logic      wa_wen,
  input  logic      wa_redirect,
  // long lane write port
  input  logic      wl_en,
  input  cb_index_t wl_index,
  input  word_t     wl_wdata,
  input  logic      wl_wen,
  input  logic      wl_redirect,
  // commit
  input  logic      commit_ready,
  output logic      commit_valid,
  output reg_addr_t commit_rd,
  output word_t     commit_wdata,
  output logic      commit_wen,
  output logic      commit_redirect,
  output logic      flush
);

  localparam int DEPTH = `OOO_CB_DEPTH;

  logic [DEPTH-1:0]  busy;                    // allocated, not yet retired
  logic [DEPTH-1:0]  done;                    // result written
  reg_addr_t         rd_q     [DEPTH];
  word_t             wdata_q  [DEPTH];
  logic [DEPTH-1:0]  wen_q;
  logic [DEPTH-1:0]  redir_q;
  cb_index_t         head;                    // oldest entry
  cb_index_t         tail;                    // next slot to hand out
  logic [$clog2(DEPTH+1)-1:0] count;

  logic alloc_go;  // dispatch handshake
  logic retire;    // commit handshake
  logic wa_hit;    // lane write lands on a live entry
  logic wl_hit;

  assign alloc_ready = (count != DEPTH[$clog2(DEPTH+1)-1:0]);
  assign alloc_index = tail;
  assign alloc_go    = alloc_valid & alloc_ready;
  assign wa_hit      = wa_en & busy[wa_index]; // stale writes are dropped
  assign wl_hit      = wl_en & busy[wl_index];

  // commit straight off the head entry
  assign commit_valid    = busy[head] & done[head];
  assign commit_rd       = rd_q[head];
  assign commit_wdata    = wdata_q[head];
  assign commit_wen      = wen_q[head];
  assign commit_redirect = redir_q[head];
  assign retire          = commit_valid & commit_ready;
  assign flush           = retire & redir_q[head]; // everything younger is wrong path

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy  <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // restart right after the redirecting entry, same-cycle dispatch is dropped
      busy  <= '0;
      done  <= '0;
      head  <= head + 1'b1;
      tail  <= head + 1'b1;
      count <= '0;
    end else begin
      if (retire) begin
        busy[head] <= 1'b0;
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      if (wa_hit) done[wa_index] <= 1'b1;
      if (wl_hit) done[wl_index] <= 1'b1;
      if (alloc_go) begin
        busy[tail] <= 1'b1;
        done[tail] <= 1'b0;   // tail is free here, no lane write can hit it
        tail       <= tail + 1'b1;
      end
      count <= count + alloc_go - retire;
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (alloc_go) rd_q[tail] <= alloc_rd;
    if (wa_hit) begin
      wdata_q[wa_index] <= wa_wdata;
      wen_q[wa_index]   <= wa_wen;
      redir_q[wa_index] <= wa_redirect;
    end
    if (wl_hit) begin
      wdata_q[wl_index] <= wl_wdata;
      wen_q[wl_index]   <= wl_wen;
      redir_q[wl_index] <= wl_redirect;
    end
  end

  // lanes only carry indices that dispatch handed out
  a_write_live: assert property (@(posedge CLK) disable iff (!nRST)
    !flush |-> (!wa_en || busy[wa_index]) && (!wl_en || busy[wl_index]));

  // a stalled commit keeps its head entry
  a_commit_hold: assert property (@(posedge CLK) disable iff (!nRST)
    commit_valid && !commit_ready |=> commit_valid);

  a_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
    count <= DEPTH);

endmodule

// ==== ooo_commit_top.sv ====
// ----------------------------------------------------------------------
// module ooo_commit_top
// two lane result registers, writeback stage and completion buffer
// ----------------------------------------------------------------------
module ooo_commit_top import ooo_types_pkg::*; (
  input  logic          CLK,
  input  logic          nRST,
  // dispatch
  input  logic          alloc_valid,
  input  reg_addr_t     alloc_rd,
  output logic          alloc_ready,
  output cb_index_t     alloc_index,
  // result lanes
  input  logic          arith_valid,
  input  arith_result_t arith_data,
  output logic          arith_ready,
  input  logic          long_valid,
  input  long_result_t  long_data,
  output logic          long_ready,
  // commit
  input  logic          commit_ready,
  output logic          commit_valid,
  output reg_addr_t     commit_rd,
  output word_t         commit_wdata,
  output logic          commit_wen,
  output logic          commit_redirect,
  // predictor
  output logic          pred_update,
  output logic          pred_taken,
  output word_t         pred_target
);

  logic          flush;                      // from the buffer to both lanes
  logic          ar_valid, lr_valid;         // registered lane results
  arith_result_t ar_data;
  long_result_t  lr_data;
  logic          wa_en, wa_wen, wa_redirect;
  cb_index_t     wa_index;
  word_t         wa_wdata;
  logic          wl_en, wl_wen, wl_redirect;
  cb_index_t     wl_index;
  word_t         wl_wdata;

  result_reg #(.payload_t(arith_result_t)) u_arith_reg (
    .CLK, .nRST, .flush, .in_valid(arith_valid), .in_data(arith_data),
    .in_ready(arith_ready), .out_valid(ar_valid), .out_data(ar_data));

  result_reg #(.payload_t(long_result_t)) u_long_reg (
    .CLK, .nRST, .flush, .in_valid(long_valid), .in_data(long_data),
    .in_ready(long_ready), .out_valid(lr_valid), .out_data(lr_data));

  ooo_writeback_stage u_wb (
    .arith_valid(ar_valid), .arith_data(ar_data), .long_valid(lr_valid),
    .long_data(lr_data), .wa_en, .wa_index, .wa_wdata, .wa_wen, .wa_redirect,
    .wl_en, .wl_index, .wl_wdata, .wl_wen, .wl_redirect,
    .pred_update, .pred_taken, .pred_target);

  completion_buffer u_cb (
    .CLK, .nRST, .alloc_valid, .alloc_rd, .alloc_ready, .alloc_index,
    .wa_en, .wa_index, .wa_wdata, .wa_wen, .wa_redirect,
    .wl_en, .wl_index, .wl_wdata, .wl_wen, .wl_redirect,
    .commit_ready, .commit_valid, .commit_rd, .commit_wdata, .commit_wen,
    .commit_redirect, .flush);

endmodule

// ==== tb_ooo_commit.sv ====
// ----------------------------------------------------------------------
// testbench for ooo_commit_top
// random dispatch and two-lane results against an in-order commit model
// predictor update, back-pressure and flush checks, watchdog
// ----------------------------------------------------------------------
`include "ooo_cfg.svh"

module tb_ooo_commit
  import ooo_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH   = `OOO_CB_DEPTH;
  localparam int N_TRANS = 2000;               // commits to reach
  localparam int WDOG_NS = N_TRANS * 40 * 40;  // 40 cycles per commit, 40 ns clock

  int seed = 45834;

  logic CLK, nRST;
  logic alloc_valid, alloc_ready, arith_valid, arith_ready, long_valid, long_ready;
  reg_addr_t alloc_rd, commit_rd;
  cb_index_t alloc_index;
  arith_result_t arith_data;
  long_result_t long_data;
  logic commit_ready, commit_valid, commit_wen, commit_redirect;
  word_t commit_wdata, pred_target;
  logic pred_update, pred_taken;

  // reference model
  cb_index_t order_q[$];            // dispatched, not retired, oldest first
  cb_index_t open_q[$];             // dispatched, no result sent yet
  reg_addr_t m_rd       [DEPTH];
  word_t     m_wdata    [DEPTH];
  logic      m_wen      [DEPTH];
  logic      m_redir    [DEPTH];
  logic      m_sent     [DEPTH];    // result accepted by a lane
  int        m_sent_cyc [DEPTH];
  cb_index_t m_tail;
  // result on the lane pins, lands at the next edge
  logic      pend_valid, pend_wen, pend_redir, pend_branch, pend_taken;
  cb_index_t pend_idx;
  word_t     pend_wdata, pend_target;
  logic      pred_due, pred_due_taken;  // branch now sitting in the result register
  word_t     pred_due_target;
  int        cycle, errors, commits, branches, updates, stall_left;

  ooo_commit_top dut (.*);

  always #20 CLK = ~CLK;

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s at cycle %0d: got %h expected %h", name, cycle, got, exp);
    end
  endtask

  task automatic check_index(input cb_index_t exp);
    if (alloc_index !== exp) begin
      errors++;
      $display("Fail alloc_index at cycle %0d: got %h expected %h", cycle, alloc_index, exp);
    end
  endtask

  task automatic check_commit(input reg_addr_t rd, input word_t wdata, input logic wen);
    if (commit_rd !== rd) begin
      errors++;
      $display("Fail commit_rd at cycle %0d: got %h expected %h", cycle, commit_rd, rd);
    end
    if (commit_wdata !== wdata) begin
      errors++;
      $display("Fail commit_wdata at cycle %0d: got %h expected %h",
               cycle, commit_wdata, wdata);
    end
    check_bit("commit_wen", commit_wen, wen);
  endtask

  task automatic check_redirect(input logic redir);
    check_bit("commit_redirect", commit_redirect, redir);
  endtask

  task automatic check_pred(input logic taken, input word_t target);
    check_bit("pred_taken", pred_taken, taken);
    if (pred_target !== target) begin
      errors++;
      $display("Fail pred_target at cycle %0d: got %h expected %h", cycle, pred_target, target);
    end
  endtask

  initial begin
    cb_index_t     head;
    logic          exp_cv, retire, flushing, xfer, alloc_took, mis;
    int            p;
    arith_result_t a;
    long_result_t  l;
    CLK = 1'b0;
    nRST = 1'b0;
    alloc_valid = 1'b0;
    alloc_rd = '0;
    arith_valid = 1'b0;
    arith_data = '0;
    long_valid = 1'b0;
    long_data = '0;
    commit_ready = 1'b0;
    m_tail = '0;
    pend_valid = 1'b0;
    pend_branch = 1'b0;
    pred_due = 1'b0;
    {cycle, errors, commits, branches, updates, stall_left} = '0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    while (commits < N_TRANS) begin
      @(posedge CLK);
      cycle++;
      // everything read here is the value the DUT samples at this edge
      head   = (order_q.size() > 0) ? order_q[0] : '0;
      exp_cv = order_q.size() > 0 && m_sent[head] && cycle >= m_sent_cyc[head] + 2;
      check_bit("commit_valid", commit_valid, exp_cv);
      if (commit_valid && exp_cv) begin
        check_commit(m_rd[head], m_wdata[head], m_wen[head]);
        check_redirect(m_redir[head]);
      end
      check_bit("alloc_ready", alloc_ready, order_q.size() < DEPTH);
      check_bit("pred_update", pred_update, pred_due);
      if (pred_update && pred_due) check_pred(pred_due_taken, pred_due_target);
      if (pred_update) updates++;
      pred_due = 1'b0;
      retire   = commit_valid && exp_cv && commit_ready;
      flushing = retire && m_redir[head];
      check_bit("arith_ready", arith_ready, !flushing);  // lanes blocked only by flush
      check_bit("long_ready", long_ready, !flushing);
      xfer       = pend_valid && ((arith_valid && arith_ready) || (long_valid && long_ready));
      alloc_took = alloc_valid && alloc_ready && !flushing;
      if (retire) begin
        commits++;
        void'(order_q.pop_front());
      end
      if (flushing) begin
        // all younger work gone, dispatch restarts after the redirecting slot
        m_tail = head + 1'b1;
        order_q.delete();
        open_q.delete();
      end else begin
        if (alloc_took) begin
          check_index(m_tail);
          m_rd[m_tail]   = alloc_rd;
          m_sent[m_tail] = 1'b0;
          order_q.push_back(m_tail);
          open_q.push_back(m_tail);
          m_tail = m_tail + 1'b1;
        end
        if (xfer) begin
          m_wdata[pend_idx]    = pend_wdata;
          m_wen[pend_idx]      = pend_wen;
          m_redir[pend_idx]    = pend_redir;
          m_sent[pend_idx]     = 1'b1;
          m_sent_cyc[pend_idx] = cycle;
          if (pend_branch) begin
            branches++;
            pred_due        = 1'b1;   // strobe seen at the next edge
            pred_due_taken  = pend_taken;
            pred_due_target = pend_target;
          end
        end
      end
      // next stimulus, dispatch held until it transfers
      if (!alloc_valid || alloc_took) begin
        alloc_valid <= rand_below(4) != 0;
        alloc_rd    <= reg_addr_t'(rand_below(`OOO_NREGS));
      end
      if (stall_left > 0) begin
        stall_left--;
        commit_ready <= 1'b0;
      end else if (rand_below(16) == 0) begin
        stall_left = 4 + rand_below(20);  // long enough to fill the buffer
        commit_ready <= 1'b0;
      end else begin
        commit_ready <= rand_below(4) != 0;
      end
      pend_valid  = 1'b0;
      pend_branch = 1'b0;
      arith_valid <= 1'b0;
      long_valid  <= 1'b0;
      if (open_q.size() > 0 && rand_below(4) != 0) begin
        p          = rand_below(open_q.size());  // any open slot, so out of order
        pend_idx   = open_q[p];
        pend_valid = 1'b1;
        open_q.delete(p);
        if (rand_below(2) == 0) begin
          p            = rand_below(16);
          a.index      = pend_idx;
          a.wdata      = $random(seed);
          a.pc         = $random(seed);
          a.target     = $random(seed);
          a.exception  = rand_below(32) == 0;
          a.jump       = p == 0;
          a.branch     = p >= 1 && p <= 4;
          a.taken      = rand_below(2) == 1;
          a.prediction = (rand_below(8) == 0) ? !a.taken : a.taken;
          // target before pc before result
          mis          = a.branch && (a.taken != a.prediction);
          pend_wdata   = (mis || a.jump) ? a.target : (a.exception ? a.pc : a.wdata);
          pend_wen     = !(a.branch || a.exception);
          pend_redir   = mis || a.jump || a.exception;
          pend_branch  = a.branch;
          pend_taken   = a.taken;
          pend_target  = a.target;
          arith_valid <= 1'b1;
          arith_data  <= a;
        end else begin
          l.index     = pend_idx;
          l.wdata     = $random(seed);
          l.pc        = $random(seed);
          l.exception = rand_below(32) == 0;
          pend_wdata  = l.exception ? l.pc : l.wdata;
          pend_wen    = !l.exception;
          pend_redir  = l.exception;
          long_valid <= 1'b1;
          long_data  <= l;
        end
      end
    end
    // a branch accepted at the last edge has not shown its strobe yet
    if (updates != branches - int'(pred_due)) begin
      errors++;
      $display("predictor updates seen (%0d) do not match branches accepted (%0d)",
               updates, branches - int'(pred_due));
    end
    $display("errors %0d, commits %0d, branches %0d, predictor updates %0d",
             errors, commits, branches, updates);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog, commits stopped coming
  initial begin
    #(WDOG_NS);
    $display("commits stopped, only %0d of %0d retired before the time limit",
             commits, N_TRANS);
    $display("errors %0d, commits %0d, branches %0d, predictor updates %0d",
             errors, commits, branches, updates);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
ooo_types_pkg.sv
result_reg.sv
ooo_writeback_stage.sv
completion_buffer.sv
ooo_commit_top.sv
tb_ooo_commit.sv

// ==== Makefile ====
# Verilator build and run of the OoO commit testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_commit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, simulator exit status alone is not enough
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
